/* src/exec_pkg.sv */
package exec_pkg;

   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   // Register map in byte addresses
   localparam logic [4:0] ADDR_OPA    = 5'h00;
   localparam logic [4:0] ADDR_OPB    = 5'h04;
   localparam logic [4:0] ADDR_CTRL   = 5'h08;
   localparam logic [4:0] ADDR_STATUS = 5'h0C;
   localparam logic [4:0] ADDR_RESULT = 5'h10;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLT  = 4'd5,
      OP_SLTU = 4'd6,
      OP_SLL  = 4'd7,
      OP_SRL  = 4'd8
   } op_t;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      INIT = 2'd1,
      RUN  = 2'd2,
      TRAP = 2'd3
   } phase_t;

   typedef enum logic [1:0] {
      CAUSE_NONE       = 2'd0,
      CAUSE_ILLEGAL_OP = 2'd1
   } cause_t;

   typedef struct packed {
      logic            start;
      op_t             op;
      logic [XLEN-1:0] opa;
      logic [XLEN-1:0] opb;
   } exec_cmd_t;

   typedef struct packed {
      phase_t           phase;
      logic [CNT_W-1:0] cnt;
      logic             cnt_en;
      logic             init;
      logic             run;
      logic             shamt_en;
      logic             load;
      logic             res_shift;
      logic             res_zero;
   } exec_ctl_t;

   typedef struct packed {
      logic   busy;
      logic   done;
      cause_t cause;
   } exec_sts_t;

endpackage

/* src/exec_state.sv */
`timescale 1ns/10ps

module exec_state import exec_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst,
   input  exec_cmd_t i_cmd,
   input  logic      i_sh_done,
   output exec_ctl_t o_ctl,
   output exec_sts_t o_sts
);

   phase_t           state;
   logic [CNT_W-1:0] cnt;
   logic             cnt_done;
   logic             cnt_en;
   logic             stage_one_done;
   logic             load;
   logic             busy;
   logic             done;
   cause_t           cause;
   logic             illegal_op;
   logic             two_stage_op;
   logic             shift_op;

   assign illegal_op = !(i_cmd.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                          OP_SLT, OP_SLTU, OP_SLL, OP_SRL});
   assign shift_op     = i_cmd.op inside {OP_SLL, OP_SRL};
   assign two_stage_op = shift_op || (i_cmd.op inside {OP_SLT, OP_SLTU});

   assign cnt_en = (state != IDLE);

   assign o_ctl = '{
      phase:     state,
      cnt:       cnt,
      cnt_en:    cnt_en,
      init:      (state == INIT),
      run:       (state == RUN),
      shamt_en:  (state == INIT) && (cnt < 5),
      load:      load,
      res_shift: (state == RUN) || (state == TRAP),
      res_zero:  (state == TRAP)
   };

   assign o_sts = '{busy: busy, done: done, cause: cause};

   always_ff @(posedge i_clk) begin
      load <= i_cmd.start; // Buffers load one cycle after the start pulse

      // High during the last bit of a phase while cnt is 31
      cnt_done <= cnt_en && (cnt == 5'd30);

      if (i_cmd.start) begin
         busy  <= 1'b1;
         done  <= 1'b0;
         cause <= CAUSE_NONE;
      end

      case (state)
         IDLE: begin
            if (load) begin
               state <= RUN;
               if (two_stage_op && !stage_one_done)
                  state <= INIT;
               if (illegal_op) begin
                  state <= TRAP;
                  cause <= CAUSE_ILLEGAL_OP;
               end
            end else if (stage_one_done && i_sh_done) begin
               state <= RUN; // Shifter has finished rotating operand A
            end
         end
         INIT: begin
            stage_one_done <= 1'b1;
            if (cnt_done)
               state <= shift_op ? IDLE : RUN;
         end
         RUN: begin
            stage_one_done <= 1'b0;
            if (cnt_done) begin
               state <= IDLE;
               busy  <= 1'b0;
               done  <= 1'b1;
            end
         end
         TRAP: begin
            if (cnt_done) begin
               state <= IDLE;
               busy  <= 1'b0;
               done  <= 1'b1;
            end
         end
         default: state <= IDLE;
      endcase

      cnt <= cnt + {{(CNT_W-1){1'b0}}, cnt_en};

      if (i_rst) begin
         state          <= IDLE;
         cnt            <= '0;
         cnt_done       <= 1'b0;
         stage_one_done <= 1'b0;
         load           <= 1'b0;
         busy           <= 1'b0;
         done           <= 1'b0;
         cause          <= CAUSE_NONE;
      end
   end

endmodule

/* src/serial_alu.sv */
`timescale 1ns/10ps

module serial_alu import exec_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst,
   input  exec_ctl_t i_ctl,
   input  op_t       i_op,
   input  logic      i_a,
   input  logic      i_b,
   output logic      o_res_bit
);

   logic             carry;
   logic             lt_flag;
   logic [CNT_W-1:0] shamt;
   logic             sub_mode;
   logic             b_eff;
   logic             c_in;
   logic             sum;
   logic             c_out;
   logic             slt_bit;
   logic             wrapped;
   logic [CNT_W:0]   cnt_plus_sh;

   assign sub_mode = i_op inside {OP_SUB, OP_SLT, OP_SLTU};
   assign b_eff    = i_b ^ sub_mode;
   assign c_in     = (i_ctl.cnt == '0) ? sub_mode : carry; // The +1 of two's complement at bit 0
   assign sum      = i_a ^ b_eff ^ c_in;
   assign c_out    = (i_a & b_eff) | (c_in & (i_a ^ b_eff));

   // When the signs differ, A is the smaller one exactly if it is negative
   assign slt_bit = (i_a ^ i_b) ? i_a : sum;

   assign cnt_plus_sh = {1'b0, i_ctl.cnt} + {1'b0, shamt};

   always_comb begin
      wrapped = 1'b0;
      if (i_op == OP_SLL)
         wrapped = (i_ctl.cnt < shamt);
      else if (i_op == OP_SRL)
         wrapped = cnt_plus_sh[CNT_W]; // Bits that came round from the other end
   end

   always_comb begin
      case (i_op)
         OP_ADD, OP_SUB: o_res_bit = sum;
         OP_AND:         o_res_bit = i_a & i_b;
         OP_OR:          o_res_bit = i_a | i_b;
         OP_XOR:         o_res_bit = i_a ^ i_b;
         OP_SLT, OP_SLTU: o_res_bit = lt_flag && (i_ctl.cnt == '0);
         OP_SLL, OP_SRL: o_res_bit = i_a && !wrapped;
         default:        o_res_bit = 1'b0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_ctl.shamt_en)
         shamt[i_ctl.cnt[2:0]] <= i_b;
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry   <= 1'b0;
         lt_flag <= 1'b0;
      end else begin
         if (i_ctl.cnt_en)
            carry <= c_out;
         // Final bit of the INIT subtraction decides the comparison
         if (i_ctl.init && (i_ctl.cnt == 5'd31))
            lt_flag <= (i_op == OP_SLTU) ? !c_out : slt_bit;
      end
   end

endmodule

/* src/serial_shifter.sv */
`timescale 1ns/10ps

module serial_shifter import exec_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst,
   input  exec_ctl_t i_ctl,
   input  op_t       i_op,
   input  logic      i_b,
   output logic      o_shift_rot,
   output logic      o_done
);

   logic [CNT_W-1:0] shamt;
   logic [CNT_W-1:0] remain;
   logic             active;
   logic             shift_op;
   logic             init_end;

   assign shift_op = i_op inside {OP_SLL, OP_SRL};
   assign init_end = i_ctl.init && (i_ctl.cnt == 5'd31);

   // One rotation of operand A per cycle until the amount is used up
   assign o_shift_rot = active && (remain != '0);
   assign o_done      = active && (remain == '0);

   always_ff @(posedge i_clk) begin
      if (i_ctl.shamt_en)
         shamt[i_ctl.cnt[2:0]] <= i_b; // B arrives LSB first
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         active <= 1'b0;
         remain <= '0;
      end else if (init_end && shift_op) begin
         active <= 1'b1;
         remain <= shamt;
      end else if (active) begin
         if (remain == '0)
            active <= 1'b0;
         else
            remain <= remain - 1'b1;
      end
   end

endmodule

/* src/operand_bufs.sv */
`timescale 1ns/10ps

module operand_bufs import exec_pkg::*; (
   input  logic            i_clk,
   input  logic            i_rst,
   input  exec_cmd_t       i_cmd,
   input  exec_ctl_t       i_ctl,
   input  logic            i_rot,
   input  logic            i_res_bit,
   output logic            o_a,
   output logic            o_b,
   output logic [XLEN-1:0] o_result
);

   logic [XLEN-1:0] a_buf;
   logic [XLEN-1:0] b_buf;
   logic            res_in;

   assign o_a = a_buf[0];
   assign o_b = b_buf[0];

   assign res_in = i_ctl.res_zero ? 1'b0 : i_res_bit;

   // Both buffers rotate so that a full phase leaves them as loaded
   always_ff @(posedge i_clk) begin
      if (i_ctl.load) begin
         a_buf <= i_cmd.opa;
         b_buf <= i_cmd.opb;
      end else if (i_ctl.cnt_en) begin
         a_buf <= {a_buf[0], a_buf[XLEN-1:1]};
         b_buf <= {b_buf[0], b_buf[XLEN-1:1]};
      end else if (i_rot) begin
         // Left for SLL, right for SRL
         if (i_cmd.op == OP_SLL)
            a_buf <= {a_buf[XLEN-2:0], a_buf[XLEN-1]};
         else
            a_buf <= {a_buf[0], a_buf[XLEN-1:1]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_result <= '0;
      else if (i_ctl.res_shift)
         o_result <= {res_in, o_result[XLEN-1:1]}; // Bit 0 ends up in place after 32 shifts
   end

endmodule

/* src/axil_regs.sv */
`timescale 1ns/10ps

module axil_regs import exec_pkg::*; (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_awvalid,
   output logic            o_awready,
   input  logic [4:0]      i_awaddr,
   input  logic            i_wvalid,
   output logic            o_wready,
   input  logic [XLEN-1:0] i_wdata,
   input  logic [3:0]      i_wstrb,
   output logic            o_bvalid,
   input  logic            i_bready,
   output logic [1:0]      o_bresp,
   input  logic            i_arvalid,
   output logic            o_arready,
   input  logic [4:0]      i_araddr,
   output logic            o_rvalid,
   input  logic            i_rready,
   output logic [XLEN-1:0] o_rdata,
   output logic [1:0]      o_rresp,
   input  exec_sts_t       i_sts,
   input  logic [XLEN-1:0] i_result,
   output exec_cmd_t       o_cmd
);

   logic [XLEN-1:0] opa;
   logic [XLEN-1:0] opb;
   op_t             op;
   logic            start;
   logic            wr_fire;
   logic            rd_fire;
   logic            ctrl_wr;
   logic [XLEN-1:0] rd_mux;

   // Address and data are taken together and only while no response is pending
   assign wr_fire   = i_awvalid && i_wvalid && !o_bvalid;
   assign o_awready = wr_fire;
   assign o_wready  = wr_fire;
   assign rd_fire   = i_arvalid && !o_rvalid;
   assign o_arready = !o_rvalid;
   assign o_bresp   = RESP_OKAY;
   assign o_rresp   = RESP_OKAY;

   // A command while busy gets its response but does nothing
   assign ctrl_wr = wr_fire && (i_awaddr == ADDR_CTRL) && !i_sts.busy && !start;

   assign o_cmd = '{start: start, op: op, opa: opa, opb: opb};

   always_comb begin
      case (i_araddr)
         ADDR_OPA:    rd_mux = opa;
         ADDR_OPB:    rd_mux = opb;
         ADDR_CTRL:   rd_mux = {{(XLEN-4){1'b0}}, op};
         ADDR_STATUS: rd_mux = {{(XLEN-4){1'b0}}, i_sts.cause, i_sts.done, i_sts.busy};
         ADDR_RESULT: rd_mux = i_result;
         default:     rd_mux = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (wr_fire) begin
         for (int i = 0; i < XLEN/8; i++) begin
            if (i_wstrb[i] && (i_awaddr == ADDR_OPA))
               opa[8*i +: 8] <= i_wdata[8*i +: 8];
            if (i_wstrb[i] && (i_awaddr == ADDR_OPB))
               opb[8*i +: 8] <= i_wdata[8*i +: 8];
         end
      end
      if (rd_fire)
         o_rdata <= rd_mux; // Held until the next accepted read
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_bvalid <= 1'b0;
         o_rvalid <= 1'b0;
         start    <= 1'b0;
         op       <= OP_ADD;
      end else begin
         if (wr_fire)
            o_bvalid <= 1'b1;
         else if (i_bready)
            o_bvalid <= 1'b0;

         if (rd_fire)
            o_rvalid <= 1'b1;
         else if (i_rready)
            o_rvalid <= 1'b0;

         start <= ctrl_wr;
         if (ctrl_wr)
            op <= op_t'(i_wdata[3:0]);
      end
   end

endmodule

/* src/serial_exec_top.sv */
`timescale 1ns/10ps

module serial_exec_top import exec_pkg::*; (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_awvalid,
   output logic            o_awready,
   input  logic [4:0]      i_awaddr,
   input  logic            i_wvalid,
   output logic            o_wready,
   input  logic [XLEN-1:0] i_wdata,
   input  logic [3:0]      i_wstrb,
   output logic            o_bvalid,
   input  logic            i_bready,
   output logic [1:0]      o_bresp,
   input  logic            i_arvalid,
   output logic            o_arready,
   input  logic [4:0]      i_araddr,
   output logic            o_rvalid,
   input  logic            i_rready,
   output logic [XLEN-1:0] o_rdata,
   output logic [1:0]      o_rresp
);

   exec_cmd_t       cmd;
   exec_ctl_t       ctl;
   exec_sts_t       sts;
   logic [XLEN-1:0] result;
   logic            a_bit;
   logic            b_bit;
   logic            res_bit;
   logic            rot;
   logic            sh_done;

   axil_regs u_regs (
      .i_clk, .i_rst,
      .i_awvalid, .o_awready, .i_awaddr, .i_wvalid, .o_wready, .i_wdata, .i_wstrb,
      .o_bvalid, .i_bready, .o_bresp,
      .i_arvalid, .o_arready, .i_araddr, .o_rvalid, .i_rready, .o_rdata, .o_rresp,
      .i_sts(sts), .i_result(result), .o_cmd(cmd)
   );

   exec_state u_state (
      .i_clk, .i_rst, .i_cmd(cmd), .i_sh_done(sh_done), .o_ctl(ctl), .o_sts(sts)
   );

   operand_bufs u_bufs (
      .i_clk, .i_rst, .i_cmd(cmd), .i_ctl(ctl), .i_rot(rot), .i_res_bit(res_bit),
      .o_a(a_bit), .o_b(b_bit), .o_result(result)
   );

   serial_alu u_alu (
      .i_clk, .i_rst, .i_ctl(ctl), .i_op(cmd.op), .i_a(a_bit), .i_b(b_bit),
      .o_res_bit(res_bit)
   );

   serial_shifter u_shifter (
      .i_clk, .i_rst, .i_ctl(ctl), .i_op(cmd.op), .i_b(b_bit),
      .o_shift_rot(rot), .o_done(sh_done)
   );

endmodule

/* bench/axil_tasks.svh */
`ifndef AXIL_TASKS_SVH
`define AXIL_TASKS_SVH

// Address and data go out together and stay up until the slave takes both
task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
   int waited;
   @(posedge clk);
   awvalid <= 1'b1;
   awaddr  <= addr;
   wvalid  <= 1'b1;
   wdata   <= data;
   wstrb   <= strb;
   waited = 0;
   @(negedge clk);
   while (!(awready && wready)) begin
      waited++;
      assert (waited < HS_LIMIT) else report_problem("Write address and data were never accepted");
      @(negedge clk);
   end
   @(posedge clk);
   awvalid <= 1'b0;
   wvalid  <= 1'b0;
   waited = 0;
   @(negedge clk);
   while (!bvalid) begin
      waited++;
      assert (waited < HS_LIMIT) else report_problem("No write response arrived");
      @(negedge clk);
   end
   assert (bresp == RESP_OKAY)
      else report_mismatch($sformatf("BRESP %b on write to %h", bresp, addr));
   @(posedge clk); // BREADY is high so the response completes on this edge
endtask

task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
   int waited;
   @(posedge clk);
   arvalid <= 1'b1;
   araddr  <= addr;
   waited = 0;
   @(negedge clk);
   while (!arready) begin
      waited++;
      assert (waited < HS_LIMIT) else report_problem("Read address was never accepted");
      @(negedge clk);
   end
   @(posedge clk);
   arvalid <= 1'b0;
   @(negedge clk);
   assert (rvalid) else report_problem("No read data arrived after the address was accepted");
   assert (rresp == RESP_OKAY)
      else report_mismatch($sformatf("RRESP %b on read from %h", rresp, addr));
   data = rdata;
   @(posedge clk);
endtask

// Polls STATUS until done is set and busy is clear
task automatic wait_done(output logic [31:0] status);
   int start_cycle;
   start_cycle = cycle_count;
   read_reg(ADDR_STATUS, status);
   while (!(status[1] && !status[0])) begin
      assert (cycle_count - start_cycle <= POLL_LIMIT)
         else report_problem("Operation did not finish within the poll limit");
      read_reg(ADDR_STATUS, status);
   end
endtask

`endif

/* bench/tb_serial_exec.sv */
`timescale 1ns/10ps

module tb_serial_exec import exec_pkg::*; ();

   localparam int SEED           = 29948;
   localparam int CLK_HALF       = 10;
   localparam int RESET_CYCLES   = 10;
   localparam int NUM_OPS        = 60;
   localparam int CYCLES_PER_OP  = 250;
   localparam int TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP;
   localparam int HS_LIMIT       = 16;
   localparam int POLL_LIMIT     = 200;
   localparam int STALL_CYCLES   = 5;
   localparam logic [31:0] CORNERS [3] = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000};

   logic        clk;
   logic        rst;
   logic        awvalid;
   logic        awready;
   logic [4:0]  awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        bvalid;
   logic        bready;
   logic [1:0]  bresp;
   logic        arvalid;
   logic        arready;
   logic [4:0]  araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   int          cycle_count = 0;

   serial_exec_top DUT (
      .i_clk(clk), .i_rst(rst),
      .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
      .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
      .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
      .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
      .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   task automatic stop_with_failure();
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic report_mismatch(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      stop_with_failure();
   endtask

   task automatic report_problem(input string msg);
      $display("At %0t ns: %s", $time, msg);
      stop_with_failure();
   endtask

`include "axil_tasks.svh"

   // Corner values show up often enough to hit carries, signs and overflow
   function automatic logic [31:0] pick_operand();
      case ($urandom_range(7, 0))
         0:       return 32'h0000_0000;
         1:       return 32'hFFFF_FFFF;
         2:       return 32'h8000_0000;
         default: return $urandom;
      endcase
   endfunction

   function automatic logic [31:0] model_result(input logic [3:0] code,
                                                input logic [31:0] a, input logic [31:0] b);
      case (code)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
         OP_SLTU: return {31'd0, a < b};
         OP_SLL:  return a << b[4:0];
         OP_SRL:  return a >> b[4:0];
         default: return 32'h0; // A trap leaves the result cleared
      endcase
   endfunction

   function automatic logic [31:0] merge_strobes(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [3:0] strb);
      logic [31:0] merged;
      merged = old_word;
      for (int i = 0; i < 4; i++)
         if (strb[i])
            merged[8*i +: 8] = new_word[8*i +: 8];
      return merged;
   endfunction

   task automatic run_op(input logic [3:0] code, input logic [31:0] a, input logic [31:0] b);
      logic [31:0] status;
      logic [31:0] result;
      logic [31:0] expected;
      logic [1:0]  cause_exp;
      expected  = model_result(code, a, b);
      cause_exp = (code inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                OP_SLT, OP_SLTU, OP_SLL, OP_SRL}) ? CAUSE_NONE : CAUSE_ILLEGAL_OP;
      write_reg(ADDR_OPA, a, 4'hF);
      write_reg(ADDR_OPB, b, 4'hF);
      write_reg(ADDR_CTRL, {28'd0, code}, 4'hF);
      wait_done(status);
      assert (status[3:2] == cause_exp)
         else report_mismatch($sformatf("op %0d ended with cause %0d", code, status[3:2]));
      read_reg(ADDR_RESULT, result);
      assert (result == expected)
         else report_mismatch($sformatf("op %0d a=%h b=%h gave %h, expected %h",
                                        code, a, b, result, expected));
   endtask

   // Holds RREADY low and watches the response stay put
   task automatic read_with_stall(input logic [4:0] addr, input logic [31:0] expected);
      logic [31:0] held;
      @(posedge clk);
      rready  <= 1'b0;
      arvalid <= 1'b1;
      araddr  <= addr;
      @(negedge clk);
      assert (arready) else report_problem("Read address was not accepted with no response pending");
      @(posedge clk);
      arvalid <= 1'b0;
      araddr  <= ADDR_STATUS; // A new address must not disturb the held data
      @(negedge clk);
      assert (rvalid) else report_problem("No read data arrived after the address was accepted");
      held = rdata;
      assert (held == expected)
         else report_mismatch($sformatf("stalled read got %h, expected %h", held, expected));
      for (int i = 0; i < STALL_CYCLES; i++) begin
         @(negedge clk);
         assert (rvalid && (rdata == held))
            else report_mismatch("RVALID or RDATA changed while RREADY was low");
         assert (!arready) else report_mismatch("ARREADY high with a read response pending");
      end
      @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      assert (!rvalid) else report_mismatch("RVALID stayed high after RREADY");
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] data;
      logic [31:0] old_word;
      logic [31:0] new_word;
      logic [3:0]  strb;
      logic [4:0]  addr;

      void'($urandom(SEED));
      rst     <= 1'b1;
      awvalid <= 1'b0;
      awaddr  <= 5'd0;
      wvalid  <= 1'b0;
      wdata   <= 32'd0;
      wstrb   <= 4'd0;
      bready  <= 1'b1;
      arvalid <= 1'b0;
      araddr  <= 5'd0;
      rready  <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      read_reg(ADDR_STATUS, data);
      assert (data == 32'h0) else report_mismatch($sformatf("STATUS after reset is %h", data));
      read_reg(ADDR_RESULT, data);
      assert (data == 32'h0) else report_mismatch($sformatf("RESULT after reset is %h", data));

      for (int i = 0; i < 3; i++) begin
         run_op(OP_ADD, pick_operand(), pick_operand());
         run_op(OP_SUB, pick_operand(), pick_operand());
         run_op(OP_AND, pick_operand(), pick_operand());
         run_op(OP_OR, pick_operand(), pick_operand());
         run_op(OP_XOR, pick_operand(), pick_operand());
      end

      // Every ordered pair of corners including equal operands
      for (int i = 0; i < 3; i++) begin
         for (int j = 0; j < 3; j++) begin
            run_op(OP_SLT, CORNERS[i], CORNERS[j]);
            run_op(OP_SLTU, CORNERS[i], CORNERS[j]);
         end
      end
      a = $urandom;
      b = $urandom;
      run_op(OP_SLT, a, b);
      run_op(OP_SLTU, a, b);

      for (int i = 0; i < 4; i++) begin
         a = $urandom | 32'h8000_0001; // Both end bits set so wrapped bits would show
         b = $urandom;
         b[4:0] = (i == 0) ? 5'd0 : (i == 1) ? 5'd31 : 5'($urandom_range(30, 1));
         run_op(OP_SLL, a, b);
         run_op(OP_SRL, a, b);
      end

      run_op(4'($urandom_range(15, 9)), pick_operand(), pick_operand());
      run_op(OP_SUB, pick_operand(), pick_operand());

      // Second CTRL write lands while the ADD is still running
      a = pick_operand();
      b = pick_operand();
      write_reg(ADDR_OPA, a, 4'hF);
      write_reg(ADDR_OPB, b, 4'hF);
      write_reg(ADDR_CTRL, {28'd0, OP_ADD}, 4'hF);
      write_reg(ADDR_CTRL, {28'd0, OP_XOR}, 4'hF);
      read_reg(ADDR_STATUS, data);
      assert (data[0]) else report_mismatch("STATUS not busy right after the command");
      wait_done(data);
      read_reg(ADDR_CTRL, data);
      assert (data[3:0] == OP_ADD)
         else report_mismatch($sformatf("CTRL opcode changed to %0d while busy", data[3:0]));
      read_reg(ADDR_RESULT, data);
      assert (data == model_result(OP_ADD, a, b))
         else report_mismatch($sformatf("ADD under a busy write gave %h", data));

      for (int i = 0; i < 6; i++) begin
         addr     = i[0] ? ADDR_OPB : ADDR_OPA;
         old_word = $urandom;
         new_word = $urandom;
         strb     = 4'($urandom_range(15, 0));
         write_reg(addr, old_word, 4'hF);
         write_reg(addr, new_word, strb);
         read_reg(addr, data);
         assert (data == merge_strobes(old_word, new_word, strb))
            else report_mismatch($sformatf("register %h read %h after strobes %b",
                                           addr, data, strb));
      end

      new_word = $urandom;
      write_reg(ADDR_OPB, new_word, 4'hF);
      read_with_stall(ADDR_OPB, new_word);

      $display("NO ERRORS");
      $finish;
   end

endmodule

/* sim.f */
+incdir+bench
src/exec_pkg.sv
src/exec_state.sv
src/serial_alu.sv
src/serial_shifter.sv
src/operand_bufs.sv
src/axil_regs.sv
src/serial_exec_top.sv
bench/tb_serial_exec.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= tb_serial_exec
RTL_TOP   ?= serial_exec_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
